// ==== compile.f ====
+incdir+.
sb_pkg.sv
sb_entry_store.sv
sb_clobber_table.sv
sb_operand_fwd.sv
scoreboard_top.sv
tb_scoreboard.sv

// ==== tb_sb_model.svh ====
/* queue model of the scoreboard, included inside tb_scoreboard after its
   signal declarations; needs sb_pkg imported by the including module */
`ifndef TB_SB_MODEL_SVH
`define TB_SB_MODEL_SVH

// expected entries, oldest first; the first n_issued have gone out on issue
sb_entry_t                exp_q [$];
int                       n_issued;
logic [TRANS_ID_BITS-1:0] next_slot;
int unsigned              wr_cnt [NR_REGS];

task automatic clear_model();
    exp_q.delete();
    n_issued  = 0;
    next_slot = '0;
    for (int r = 0; r < NR_REGS; r++) begin
        wr_cnt[r] = 0;
    end
endtask

// slots are handed out in order from zero after reset or flush
task automatic push_decoded(input sb_entry_t e);
    sb_entry_t s;
    s          = e;
    s.trans_id = next_slot;
    s.done     = 1'b0;
    exp_q.push_back(s);
    next_slot = next_slot + 1'b1;
    if (s.rd != '0) begin
        wr_cnt[s.rd]++;
    end
endtask

task automatic write_result(input logic [TRANS_ID_BITS-1:0] id,
                            input logic [DATA_BITS-1:0] data);
    sb_entry_t s;
    for (int i = 0; i < n_issued; i++) begin
        if (exp_q[i].trans_id == id) begin
            s        = exp_q[i];
            s.result = data;
            s.done   = 1'b1;
            exp_q[i] = s;
        end
    end
endtask

task automatic retire_head();
    sb_entry_t s;
    s = exp_q.pop_front();
    n_issued--;
    if (s.rd != '0) begin
        wr_cnt[s.rd]--;
    end
endtask

function automatic logic [NR_REGS-1:0] clobber_vector();
    logic [NR_REGS-1:0] v;
    for (int r = 0; r < NR_REGS; r++) begin
        v[r] = (wr_cnt[r] != 0);
    end
    return v;
endfunction

// later entries are younger, so the last match decides
task automatic youngest_writer(input logic [REG_ADDR_BITS-1:0] rs,
                               output logic valid,
                               output logic [DATA_BITS-1:0] data);
    valid = 1'b0;
    data  = '0;
    if (rs != '0) begin
        for (int i = 0; i < exp_q.size(); i++) begin
            if (exp_q[i].rd == rs) begin
                valid = exp_q[i].done;
                data  = exp_q[i].result;
            end
        end
    end
endtask

`endif

// ==== tb_scoreboard.sv ====
/* random traffic on every port of scoreboard_top, checked each cycle against
   the queue model; the run stops at the first mismatch */
`timescale 1ns/1ps

module tb_scoreboard import sb_pkg::*; ();

    localparam int unsigned CLK_PERIOD   = 100;
    localparam int unsigned RESET_CYCLES = 16;
    localparam int unsigned NUM_CYCLES   = 3000;
    localparam int unsigned TIMEOUT_NS   = 3 * (RESET_CYCLES + NUM_CYCLES) * CLK_PERIOD;

    logic                     clk_i;
    logic                     rst_i;
    logic                     flush_i;
    logic                     decoded_valid_i;
    sb_entry_t                decoded_instr_i;
    logic                     decoded_ready_o;
    logic                     issue_valid_o;
    sb_entry_t                issue_instr_o;
    logic                     issue_ready_i;
    logic                     wb_valid_i;
    sb_wb_t                   wb_i;
    logic                     commit_valid_o;
    sb_entry_t                commit_instr_o;
    logic                     commit_ready_i;
    logic [NR_REGS-1:0]       rd_clobber_o;
    logic [REG_ADDR_BITS-1:0] rs1_i;
    logic [DATA_BITS-1:0]     rs1_o;
    logic                     rs1_valid_o;
    logic [REG_ADDR_BITS-1:0] rs2_i;
    logic [DATA_BITS-1:0]     rs2_o;
    logic                     rs2_valid_o;

    logic [31:0] rng_state;

    // handshakes that the coming edge will perform
    logic                     hs_flush;
    logic                     hs_alloc;
    sb_entry_t                hs_entry;
    logic                     hs_issue;
    logic                     hs_commit;
    logic                     hs_wb;
    logic [TRANS_ID_BITS-1:0] hs_wb_id;
    logic [DATA_BITS-1:0]     hs_wb_data;

    `include "tb_sb_model.svh"

    scoreboard_top dut (.*);

    initial clk_i = 1'b0;
    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    // --------------------------------------------------
    // helpers
    // --------------------------------------------------
    function automatic logic [31:0] next_rand();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    // mostly x0..x7 so that writers and lookups collide often
    function automatic logic [REG_ADDR_BITS-1:0] pick_reg(input logic [31:0] r);
        return r[5] ? r[4:0] : {2'b00, r[2:0]};
    endfunction

    task automatic check_value(input string name, input logic [127:0] exp_val,
                               input logic [127:0] act_val);
        if (act_val !== exp_val) begin
            $display("[ERROR] %s expected %h got %h", name, exp_val, act_val);
            $display("sim failed");
            $fatal(1, "%s does not match the model", name);
        end
    endtask

    // --------------------------------------------------
    // compare every output with the model at the falling edge
    // --------------------------------------------------
    task automatic check_outputs();
        logic                 exp_commit;
        logic                 exp_valid;
        logic [DATA_BITS-1:0] exp_data;
        check_value("decoded_ready_o", exp_q.size() < NR_ENTRIES, decoded_ready_o);
        check_value("issue_valid_o", n_issued < exp_q.size(), issue_valid_o);
        if (n_issued < exp_q.size()) begin
            check_value("issue_instr_o", exp_q[n_issued], issue_instr_o);
        end
        exp_commit = 1'b0;
        if (n_issued > 0) begin
            exp_commit = exp_q[0].done;
        end
        check_value("commit_valid_o", exp_commit, commit_valid_o);
        if (exp_commit) begin
            check_value("commit_instr_o", exp_q[0], commit_instr_o);
        end
        check_value("rd_clobber_o", clobber_vector(), rd_clobber_o);
        youngest_writer(rs1_i, exp_valid, exp_data);
        check_value("rs1_valid_o", exp_valid, rs1_valid_o);
        if (exp_valid) begin
            check_value("rs1_o", exp_data, rs1_o);
        end
        youngest_writer(rs2_i, exp_valid, exp_data);
        check_value("rs2_valid_o", exp_valid, rs2_valid_o);
        if (exp_valid) begin
            check_value("rs2_o", exp_data, rs2_o);
        end
        hs_flush   = flush_i;
        hs_alloc   = decoded_valid_i && (exp_q.size() < NR_ENTRIES);
        hs_entry   = decoded_instr_i;
        hs_issue   = issue_ready_i && (n_issued < exp_q.size());
        hs_commit  = commit_ready_i && exp_commit;
        hs_wb      = wb_valid_i;
        hs_wb_id   = wb_i.trans_id;
        hs_wb_data = wb_i.data;
    endtask

    // flush wins over everything else at the same edge
    task automatic update_model();
        if (hs_flush) begin
            clear_model();
        end else begin
            if (hs_wb) begin
                write_result(hs_wb_id, hs_wb_data);
            end
            if (hs_commit) begin
                retire_head();
            end
            if (hs_issue) begin
                n_issued++;
            end
            if (hs_alloc) begin
                push_decoded(hs_entry);
            end
        end
    endtask

    task automatic drive_inputs();
        sb_entry_t   e;
        sb_wb_t      w;
        logic [31:0] r;
        int          cand [$];
        r = next_rand();
        flush_i         <= (r[6:0] == 7'd0);
        decoded_valid_i <= (r[9:8] != 2'b00);
        issue_ready_i   <= (r[11:10] != 2'b00);
        commit_ready_i  <= r[12];
        rs1_i           <= pick_reg(next_rand());
        rs2_i           <= pick_reg(next_rand());
        r          = next_rand();
        e.pc       = next_rand();
        e.trans_id = r[2:0];
        e.fu       = fu_e'(r[4:3]);
        e.op       = fu_op_e'(r[7:5]);
        e.rd       = pick_reg(next_rand());
        e.rs1      = pick_reg(next_rand());
        e.rs2      = pick_reg(next_rand());
        e.result   = {next_rand(), next_rand()};
        e.done     = r[8];
        decoded_instr_i <= e;
        // writeback goes to a random issued entry still waiting for its result
        for (int i = 0; i < n_issued; i++) begin
            if (!exp_q[i].done) begin
                cand.push_back(exp_q[i].trans_id);
            end
        end
        r = next_rand();
        w = '0;
        if ((cand.size() > 0) && r[0]) begin
            w.trans_id = cand[r[31:16] % cand.size()];
            w.data     = {next_rand(), next_rand()};
        end
        wb_valid_i <= (cand.size() > 0) && r[0];
        wb_i       <= w;
    endtask

    // --------------------------------------------------
    // main sequence and watchdog
    // --------------------------------------------------
    initial begin
        rng_state       = 32'h2bb9;
        rst_i           = 1'b1;
        flush_i         = 1'b0;
        decoded_valid_i = 1'b0;
        decoded_instr_i = '0;
        issue_ready_i   = 1'b0;
        wb_valid_i      = 1'b0;
        wb_i            = '0;
        commit_ready_i  = 1'b0;
        rs1_i           = '0;
        rs2_i           = '0;
        clear_model();
        repeat (RESET_CYCLES) @(posedge clk_i);
        rst_i <= 1'b0;
        for (int cyc = 0; cyc < NUM_CYCLES; cyc++) begin
            @(negedge clk_i);
            check_outputs();
            @(posedge clk_i);
            update_model();
            drive_inputs();
        end
        $display("sim passed");
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("timeout: the run did not reach its end within %0d ns", TIMEOUT_NS);
        $display("sim failed");
        $fatal(1, "watchdog expired");
    end

endmodule

// ==== scoreboard_top.sv ====
/* scoreboard of NR_ENTRIES in-flight instructions with one commit port;
   writebacks have no back-pressure */
`timescale 1ns/1ps

module scoreboard_top import sb_pkg::*; (
    input  logic                     clk_i,
    input  logic                     rst_i,
    input  logic                     flush_i,
    input  logic                     decoded_valid_i,
    input  sb_entry_t                decoded_instr_i,
    output logic                     decoded_ready_o,
    output logic                     issue_valid_o,
    output sb_entry_t                issue_instr_o,
    input  logic                     issue_ready_i,
    input  logic                     wb_valid_i,
    input  sb_wb_t                   wb_i,
    output logic                     commit_valid_o,
    output sb_entry_t                commit_instr_o,
    input  logic                     commit_ready_i,
    output logic [NR_REGS-1:0]       rd_clobber_o,
    input  logic [REG_ADDR_BITS-1:0] rs1_i,
    output logic [DATA_BITS-1:0]     rs1_o,
    output logic                     rs1_valid_o,
    input  logic [REG_ADDR_BITS-1:0] rs2_i,
    output logic [DATA_BITS-1:0]     rs2_o,
    output logic                     rs2_valid_o
);

    sb_entry_t [NR_ENTRIES-1:0] entries;
    logic [NR_ENTRIES-1:0]      inflight;
    logic [TRANS_ID_BITS-1:0]   commit_ptr;
    logic                       alloc_valid;
    logic [REG_ADDR_BITS-1:0]   alloc_rd;
    logic                       free_valid;
    logic [REG_ADDR_BITS-1:0]   free_rd;

    sb_entry_store i_store (
        .clk_i           ( clk_i           ),
        .rst_i           ( rst_i           ),
        .flush_i         ( flush_i         ),
        .decoded_valid_i ( decoded_valid_i ),
        .decoded_instr_i ( decoded_instr_i ),
        .decoded_ready_o ( decoded_ready_o ),
        .issue_valid_o   ( issue_valid_o   ),
        .issue_instr_o   ( issue_instr_o   ),
        .issue_ready_i   ( issue_ready_i   ),
        .wb_valid_i      ( wb_valid_i      ),
        .wb_i            ( wb_i            ),
        .commit_valid_o  ( commit_valid_o  ),
        .commit_instr_o  ( commit_instr_o  ),
        .commit_ready_i  ( commit_ready_i  ),
        .entries_o       ( entries         ),
        .inflight_o      ( inflight        ),
        .commit_ptr_o    ( commit_ptr      ),
        .alloc_valid_o   ( alloc_valid     ),
        .alloc_rd_o      ( alloc_rd        ),
        .free_valid_o    ( free_valid      ),
        .free_rd_o       ( free_rd         )
    );

    sb_clobber_table i_clobber (
        .clk_i         ( clk_i        ),
        .rst_i         ( rst_i        ),
        .flush_i       ( flush_i      ),
        .alloc_valid_i ( alloc_valid  ),
        .alloc_rd_i    ( alloc_rd     ),
        .free_valid_i  ( free_valid   ),
        .free_rd_i     ( free_rd      ),
        .rd_clobber_o  ( rd_clobber_o )
    );

    sb_operand_fwd i_fwd (
        .entries_i    ( entries     ),
        .inflight_i   ( inflight    ),
        .commit_ptr_i ( commit_ptr  ),
        .rs1_i        ( rs1_i       ),
        .rs2_i        ( rs2_i       ),
        .rs1_o        ( rs1_o       ),
        .rs1_valid_o  ( rs1_valid_o ),
        .rs2_o        ( rs2_o       ),
        .rs2_valid_o  ( rs2_valid_o )
    );

endmodule

// ==== sb_operand_fwd.sv ====
/* purely combinational; data is valid only if the youngest in-flight writer
   of the register is done, and x0 never forwards */
`timescale 1ns/1ps

module sb_operand_fwd import sb_pkg::*; (
    input  sb_entry_t [NR_ENTRIES-1:0] entries_i,
    input  logic [NR_ENTRIES-1:0]      inflight_i,
    input  logic [TRANS_ID_BITS-1:0]   commit_ptr_i,
    input  logic [REG_ADDR_BITS-1:0]   rs1_i,
    input  logic [REG_ADDR_BITS-1:0]   rs2_i,
    output logic [DATA_BITS-1:0]       rs1_o,
    output logic                       rs1_valid_o,
    output logic [DATA_BITS-1:0]       rs2_o,
    output logic                       rs2_valid_o
);

    typedef struct packed {
        logic                 hit;
        logic                 done;
        logic [DATA_BITS-1:0] data;
    } fwd_t;

    fwd_t fwd_rs1;
    fwd_t fwd_rs2;

    // --------------------------------------------------
    // youngest writer search
    // --------------------------------------------------
    // walk from the head towards the tail, so a later match overrides
    function automatic fwd_t lookup(input logic [REG_ADDR_BITS-1:0] rs);
        fwd_t                     res;
        logic [TRANS_ID_BITS-1:0] slot;
        res = '0;
        for (int i = 0; i < NR_ENTRIES; i++) begin
            slot = commit_ptr_i + TRANS_ID_BITS'(i);
            if (inflight_i[slot] && (entries_i[slot].rd == rs) && (rs != '0)) begin
                res.hit  = 1'b1;
                res.done = entries_i[slot].done;
                res.data = entries_i[slot].result;
            end
        end
        return res;
    endfunction

    always_comb begin
        fwd_rs1 = lookup(rs1_i);
        fwd_rs2 = lookup(rs2_i);
    end

    // --------------------------------------------------
    // outputs
    // --------------------------------------------------
    assign rs1_o       = fwd_rs1.data;
    assign rs1_valid_o = fwd_rs1.hit && fwd_rs1.done;
    assign rs2_o       = fwd_rs2.data;
    assign rs2_valid_o = fwd_rs2.hit && fwd_rs2.done;

endmodule

// ==== sb_clobber_table.sv ====
/* counts in-flight writers per register; x0 is never counted */
`timescale 1ns/1ps

module sb_clobber_table import sb_pkg::*; (
    input  logic                     clk_i,
    input  logic                     rst_i,
    input  logic                     flush_i,
    input  logic                     alloc_valid_i,
    input  logic [REG_ADDR_BITS-1:0] alloc_rd_i,
    input  logic                     free_valid_i,
    input  logic [REG_ADDR_BITS-1:0] free_rd_i,
    output logic [NR_REGS-1:0]       rd_clobber_o
);

    logic [NR_REGS-1:0][CNT_BITS-1:0] cnt_q;
    logic [NR_REGS-1:0]               inc;
    logic [NR_REGS-1:0]               dec;

    always_comb begin
        for (int r = 0; r < NR_REGS; r++) begin
            inc[r] = alloc_valid_i && (alloc_rd_i == REG_ADDR_BITS'(r)) && (r != 0);
            dec[r] = free_valid_i && (free_rd_i == REG_ADDR_BITS'(r)) && (r != 0);
            rd_clobber_o[r] = (cnt_q[r] != '0);
        end
    end

    // alloc and free on the same register leave the count unchanged
    always_ff @(posedge clk_i) begin
        if (rst_i || flush_i) begin
            cnt_q <= '0;
        end else begin
            for (int r = 0; r < NR_REGS; r++) begin
                if (inc[r] && !dec[r]) begin
                    cnt_q[r] <= cnt_q[r] + 1'b1;
                end else if (dec[r] && !inc[r]) begin
                    cnt_q[r] <= cnt_q[r] - 1'b1;
                end
            end
        end
    end

endmodule

// ==== sb_entry_store.sv ====
/* circular buffer of NR_ENTRIES; writebacks outside the issued, uncommitted
   window are dropped, and flush wins over every handshake */
`timescale 1ns/1ps

module sb_entry_store import sb_pkg::*; (
    input  logic                                clk_i,
    input  logic                                rst_i,
    input  logic                                flush_i,
    // decode side
    input  logic                                decoded_valid_i,
    input  sb_entry_t                           decoded_instr_i,
    output logic                                decoded_ready_o,
    // issue side
    output logic                                issue_valid_o,
    output sb_entry_t                           issue_instr_o,
    input  logic                                issue_ready_i,
    // writeback
    input  logic                                wb_valid_i,
    input  sb_wb_t                              wb_i,
    // commit side
    output logic                                commit_valid_o,
    output sb_entry_t                           commit_instr_o,
    input  logic                                commit_ready_i,
    // views for forwarding
    output sb_entry_t [NR_ENTRIES-1:0]          entries_o,
    output logic [NR_ENTRIES-1:0]               inflight_o,
    output logic [TRANS_ID_BITS-1:0]            commit_ptr_o,
    // events for the clobber table
    output logic                                alloc_valid_o,
    output logic [REG_ADDR_BITS-1:0]            alloc_rd_o,
    output logic                                free_valid_o,
    output logic [REG_ADDR_BITS-1:0]            free_rd_o
);

    sb_entry_t [NR_ENTRIES-1:0] mem_q;

    logic [PTR_BITS-1:0] wr_ptr_q;
    logic [PTR_BITS-1:0] iss_ptr_q;
    logic [PTR_BITS-1:0] cmt_ptr_q;

    logic [TRANS_ID_BITS-1:0] wr_idx;
    logic [TRANS_ID_BITS-1:0] iss_idx;
    logic [TRANS_ID_BITS-1:0] cmt_idx;

    logic [PTR_BITS-1:0]      used_cnt;
    logic [PTR_BITS-1:0]      issued_cnt;
    logic [TRANS_ID_BITS-1:0] wb_off;

    logic full;
    logic do_alloc;
    logic do_issue;
    logic do_commit;
    logic do_wb;

    assign wr_idx  = wr_ptr_q[TRANS_ID_BITS-1:0];
    assign iss_idx = iss_ptr_q[TRANS_ID_BITS-1:0];
    assign cmt_idx = cmt_ptr_q[TRANS_ID_BITS-1:0];

    // --------------------------------------------------
    // occupancy and handshakes
    // --------------------------------------------------
    // same slot index with opposite wrap bits means every slot is taken
    assign full = (wr_idx == cmt_idx) && (wr_ptr_q[TRANS_ID_BITS] != cmt_ptr_q[TRANS_ID_BITS]);

    assign used_cnt   = wr_ptr_q - cmt_ptr_q;
    assign issued_cnt = iss_ptr_q - cmt_ptr_q;

    assign decoded_ready_o = !full;
    assign issue_valid_o   = (iss_ptr_q != wr_ptr_q);
    assign issue_instr_o   = mem_q[iss_idx];
    assign commit_valid_o  = (cmt_ptr_q != iss_ptr_q) && mem_q[cmt_idx].done;
    assign commit_instr_o  = mem_q[cmt_idx];

    assign do_alloc  = decoded_valid_i && decoded_ready_o && !flush_i;
    assign do_issue  = issue_valid_o && issue_ready_i && !flush_i;
    assign do_commit = commit_valid_o && commit_ready_i && !flush_i;

    // distance of the written slot from the head, must lie in the issued window
    assign wb_off = wb_i.trans_id - cmt_idx;
    assign do_wb  = wb_valid_i && ({1'b0, wb_off} < issued_cnt) && !flush_i;

    // --------------------------------------------------
    // slot views
    // --------------------------------------------------
    always_comb begin
        for (int i = 0; i < NR_ENTRIES; i++) begin
            inflight_o[i] = ({1'b0, TRANS_ID_BITS'(i) - cmt_idx} < used_cnt);
        end
    end

    assign entries_o    = mem_q;
    assign commit_ptr_o = cmt_idx;

    assign alloc_valid_o = do_alloc;
    assign alloc_rd_o    = decoded_instr_i.rd;
    assign free_valid_o  = do_commit;
    assign free_rd_o     = commit_instr_o.rd;

    // --------------------------------------------------
    // pointers
    // --------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (rst_i || flush_i) begin
            wr_ptr_q  <= '0;
            iss_ptr_q <= '0;
            cmt_ptr_q <= '0;
        end else begin
            if (do_alloc) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (do_issue) begin
                iss_ptr_q <= iss_ptr_q + 1'b1;
            end
            if (do_commit) begin
                cmt_ptr_q <= cmt_ptr_q + 1'b1;
            end
        end
    end

    // entry payload, the two write slots never collide
    always_ff @(posedge clk_i) begin
        if (do_alloc) begin
            mem_q[wr_idx]          <= decoded_instr_i;
            mem_q[wr_idx].trans_id <= wr_idx;
            mem_q[wr_idx].done     <= 1'b0;
        end
        if (do_wb) begin
            mem_q[wb_i.trans_id].result <= wb_i.data;
            mem_q[wb_i.trans_id].done   <= 1'b1;
        end
    end

endmodule

// ==== sb_pkg.sv ====
/* shared scoreboard parameters and types; NR_ENTRIES must be a power of two
   and TRANS_ID_BITS its log2 */
package sb_pkg;

    // --------------------------------------------------
    // sizes
    // --------------------------------------------------
    localparam int unsigned NR_ENTRIES    = 8;
    localparam int unsigned TRANS_ID_BITS = 3;
    localparam int unsigned REG_ADDR_BITS = 5;
    localparam int unsigned NR_REGS       = 32;
    localparam int unsigned DATA_BITS     = 64;

    // pointers carry one extra wrap bit to tell full from empty
    localparam int unsigned PTR_BITS = TRANS_ID_BITS + 1;

    // writer counter has to hold NR_ENTRIES itself
    localparam int unsigned CNT_BITS = TRANS_ID_BITS + 1;

    // --------------------------------------------------
    // encodings
    // --------------------------------------------------
    typedef enum logic [1:0] {
        FU_ALU  = 2'd0,
        FU_LSU  = 2'd1,
        FU_MULT = 2'd2,
        FU_CSR  = 2'd3
    } fu_e;

    typedef enum logic [2:0] {
        OP_ADD   = 3'd0,
        OP_SUB   = 3'd1,
        OP_AND   = 3'd2,
        OP_OR    = 3'd3,
        OP_LOAD  = 3'd4,
        OP_STORE = 3'd5,
        OP_MUL   = 3'd6,
        OP_CSRRW = 3'd7
    } fu_op_e;

    // --------------------------------------------------
    // entry and writeback
    // --------------------------------------------------
    typedef struct packed {
        logic [31:0]              pc;
        logic [TRANS_ID_BITS-1:0] trans_id;  // slot index, set by the store
        fu_e                      fu;
        fu_op_e                   op;
        logic [REG_ADDR_BITS-1:0] rd;
        logic [REG_ADDR_BITS-1:0] rs1;
        logic [REG_ADDR_BITS-1:0] rs2;
        logic [DATA_BITS-1:0]     result;
        logic                     done;
    } sb_entry_t;

    typedef struct packed {
        logic [TRANS_ID_BITS-1:0] trans_id;
        logic [DATA_BITS-1:0]     data;
    } sb_wb_t;

endpackage
